/* spiFlash_stimulus.txt */
# op addr(hex) count(dec) b0..b7(hex): I id, R read, S status, C raw frame, P program, X erase
# b0..b7 are the bytes sent for C and P, the bytes expected for I, R and S
I 000 4 01 02 07 01 00 00 00 00
R 123 2 FF FF 00 00 00 00 00 00
S 000 1 00 00 00 00 00 00 00 00
C 000 1 06 00 00 00 00 00 00 00
S 000 1 02 00 00 00 00 00 00 00
C 000 1 5A 00 00 00 00 00 00 00
S 000 1 02 00 00 00 00 00 00 00
C 000 1 04 00 00 00 00 00 00 00
S 000 1 00 00 00 00 00 00 00 00
C 000 2 06 00 00 00 00 00 00 00
S 000 1 00 00 00 00 00 00 00 00
P 010 4 00 00 00 00 00 00 00 00
R 010 4 FF FF FF FF 00 00 00 00
C 000 1 06 00 00 00 00 00 00 00
P 010 4 F0 0F AA 55 00 00 00 00
R 010 4 F0 0F AA 55 00 00 00 00
C 000 1 06 00 00 00 00 00 00 00
P 010 4 3C 3C 3C 3C 00 00 00 00
R 00F 6 FF 30 0C 28 14 FF 00 00
C 000 1 06 00 00 00 00 00 00 00
P 000 1 A5 00 00 00 00 00 00 00
R FFF 2 FF A5 00 00 00 00 00 00
C 000 1 06 00 00 00 00 00 00 00
P 0FE 4 11 22 33 44 00 00 00 00
R 0FC 6 FF FF 11 22 FF FF 00 00
C 000 1 06 00 00 00 00 00 00 00
P 3FF 1 77 00 00 00 00 00 00 00
C 000 1 06 00 00 00 00 00 00 00
P 400 2 12 34 00 00 00 00 00 00
C 000 1 06 00 00 00 00 00 00 00
P 7FE 2 56 78 00 00 00 00 00 00
C 000 1 06 00 00 00 00 00 00 00
P 800 2 9A BC 00 00 00 00 00 00
R 3FE 4 FF 77 12 34 00 00 00 00
X 400 0 00 00 00 00 00 00 00 00
R 400 2 12 34 00 00 00 00 00 00
C 000 1 06 00 00 00 00 00 00 00
X 5A0 0 00 00 00 00 00 00 00 00
R 3FE 4 FF 77 FF FF 00 00 00 00
R 7FE 4 FF FF 9A BC 00 00 00 00
R 010 2 30 0C 00 00 00 00 00 00

/* spiFlash.f */
spiFlashPkg.sv
spiShiftIn.sv
cmdDecoder.sv
flashCore.sv
spiShiftOut.sv
spiFlash.sv
spiFlash_asserts.sv
spiFlash_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the serial flash testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module spiFlash_tb -f spiFlash.f || exit 1
./obj_dir/VspiFlash_tb > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

/* spiFlash_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Serial flash testbench
// Replays the stimulus records over SPI and checks the returned bytes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spiFlash_tb import spiFlashPkg::*;
();

    localparam int phaseCycles = 8;
    localparam int maxRecords = 64;
    localparam int recordBudgetNs = 40000;

    logic CSNeg_ipd;
    logic rstN;
    logic sck;
    logic si;
    logic csNeg;
    logic so;
    logic soEn;

    logic [7:0] opList [maxRecords];
    flashAddr_t addrList [maxRecords];
    int countList [maxRecords];
    flashByte_t dataList [maxRecords][8];
    int recordCount;
    int currentRecord;
    logic stimulusLoaded;

    spiFlash spiFlash_inst (
        .CSNeg_ipd(CSNeg_ipd), .rstN(rstN), .sck(sck), .si(si), .csNeg(csNeg),
        .so(so), .soEn(soEn)
    );

    always #4 CSNeg_ipd = ~CSNeg_ipd;

    task automatic abortRun();
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkByte(input flashByte_t expected, input flashByte_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t ns: record %0d read data expected %02h, got %02h",
                     $time, currentRecord, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkStatus(input flashByte_t expected, input flashByte_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t ns: record %0d status expected %02h, got %02h",
                     $time, currentRecord, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkEnable(input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t ns: record %0d soEn expected %0b, got %0b",
                     $time, currentRecord, expected, actual);
            abortRun();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus file reader
    ////////////////////////////////////////////////////////////////////////////
    task automatic loadStimulus();
        int fd;
        int n;
        string line;
        logic [7:0] op;
        logic [11:0] addr;
        int count;
        flashByte_t d [8];
        fd = $fopen("spiFlash_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open spiFlash_stimulus.txt");
            abortRun();
        end
        recordCount = 0;
        while ($fgets(line, fd) != 0)
        begin
            // Skip comments and blank lines
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == 8'h0a)
                continue;
            n = $sscanf(line, "%c %h %d %h %h %h %h %h %h %h %h", op, addr, count,
                        d[0], d[1], d[2], d[3], d[4], d[5], d[6], d[7]);
            if (n != 11 || count > 8 || recordCount == maxRecords)
            begin
                $display("ERROR: malformed stimulus line or too many records: %s", line);
                abortRun();
            end
            opList[recordCount] = op;
            addrList[recordCount] = addr;
            countList[recordCount] = count;
            for (int k = 0; k < 8; k++)
                dataList[recordCount][k] = d[k];
            recordCount++;
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // SPI mode 0 host, inputs change on the falling CSNeg_ipd edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic waitCycles(input int n);
        repeat (n) @(negedge CSNeg_ipd);
    endtask

    task automatic beginFrame();
        csNeg = 1'b0;
        waitCycles(phaseCycles);
    endtask

    task automatic endFrame();
        waitCycles(phaseCycles);
        csNeg = 1'b1;
        waitCycles(phaseCycles);
    endtask

    // so is sampled just before the rising sck
    task automatic transferByte(input flashByte_t txVal, output flashByte_t rxVal);
        int i;
        for (i = 7; i >= 0; i--)
        begin
            si = txVal[i];
            waitCycles(phaseCycles);
            rxVal[i] = so;
            sck = 1'b1;
            waitCycles(phaseCycles);
            sck = 1'b0;
        end
    endtask

    task automatic sendAddress(input flashAddr_t addr);
        flashByte_t dummy;
        transferByte(8'h00, dummy);
        transferByte({4'h0, addr[11:8]}, dummy);
        transferByte(addr[7:0], dummy);
    endtask

    task automatic readStatusByte(output flashByte_t value);
        flashByte_t dummy;
        beginFrame();
        transferByte(opRdsr, dummy);
        transferByte(8'h00, value);
        endFrame();
    endtask

    // WIP and WEL both drop once program or erase is done
    task automatic waitWhileBusy();
        flashByte_t value;
        readStatusByte(value);
        while (value[statusWipBit])
            readStatusByte(value);
        checkStatus(8'h00, value);
    endtask

    task automatic runRecord(input int r);
        flashByte_t got;
        flashByte_t dummy;
        int k;
        currentRecord = r;
        case (opList[r])
            "I", "R":
            begin
                beginFrame();
                if (opList[r] == "R")
                begin
                    transferByte(opRead, dummy);
                    sendAddress(addrList[r]);
                end
                else
                    transferByte(opRdid, dummy);
                for (k = 0; k < countList[r]; k++)
                begin
                    transferByte(8'h00, got);
                    checkByte(dataList[r][k], got);
                    // Output stays driven until csNeg rises
                    checkEnable(1'b1, soEn);
                end
                endFrame();
                checkEnable(1'b0, soEn);
            end
            "S":
            begin
                readStatusByte(got);
                checkStatus(dataList[r][0], got);
            end
            "C":
            begin
                beginFrame();
                for (k = 0; k < countList[r]; k++)
                    transferByte(dataList[r][k], dummy);
                endFrame();
            end
            "P", "X":
            begin
                beginFrame();
                transferByte((opList[r] == "P") ? opPp : opSe, dummy);
                sendAddress(addrList[r]);
                for (k = 0; k < countList[r]; k++)
                    transferByte(dataList[r][k], dummy);
                endFrame();
                waitWhileBusy();
            end
            default:
            begin
                $display("ERROR: unknown operation in stimulus record %0d", r);
                abortRun();
            end
        endcase
    endtask

    initial
    begin
        int r;
        CSNeg_ipd = 1'b0;
        rstN = 1'b0;
        sck = 1'b0;
        si = 1'b0;
        csNeg = 1'b1;
        currentRecord = 0;
        stimulusLoaded = 1'b0;
        loadStimulus();
        stimulusLoaded = 1'b1;
        repeat (16) @(negedge CSNeg_ipd);
        rstN = 1'b1;
        waitCycles(phaseCycles);
        for (r = 0; r < recordCount; r++)
            runRecord(r);
        $display("Test OK");
        $finish;
    end

    // Watchdog, budget per record
    initial
    begin
        wait (stimulusLoaded === 1'b1);
        #(recordCount * recordBudgetNs);
        $display("ERROR: timeout, run exceeded %0d us for %0d records",
                 recordCount * 40, recordCount);
        abortRun();
    end

endmodule

`default_nettype wire

/* spiFlash_asserts.sv */
////////////////////////////////////////////////////////////////////////////
// Serial flash output checks, bound to the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spiFlash_asserts (
    input wire CSNeg_ipd,
    input wire rstN,
    input wire csNeg,
    input wire so,
    input wire soEn
);

    // csNeg high long enough to pass the synchronizer and the output register
    assert property (@(posedge CSNeg_ipd) disable iff (!rstN)
        (csNeg && $past(csNeg, 1) && $past(csNeg, 2) && $past(csNeg, 3)
         && $past(csNeg, 4)) |-> !soEn)
        else $error("soEn high while deselected");

    assert property (@(posedge CSNeg_ipd) disable iff (!rstN) !soEn |-> !so)
        else $error("so not 0 while output disabled");

    assert property (@(posedge CSNeg_ipd) $rose(rstN) |-> !soEn)
        else $error("soEn not low after reset");

endmodule

bind spiFlash spiFlash_asserts spiFlash_asserts_inst (
    .CSNeg_ipd(CSNeg_ipd), .rstN(rstN), .csNeg(csNeg), .so(so), .soEn(soEn)
);

`default_nettype wire

/* spiFlash.sv */
////////////////////////////////////////////////////////////////////////////
// Serial flash slave, top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spiFlash import spiFlashPkg::*;
(
    input  wire  CSNeg_ipd,
    input  wire  rstN,
    input  wire  sck,
    input  wire  si,
    input  wire  csNeg,
    output logic so,
    output logic soEn
);

    logic frameStart;
    logic frameEnd;
    logic rxValid;
    flashByte_t rxByte;
    logic partialBits;
    logic sckFall;
    logic cmdValid;
    spiOpcode_e cmd;
    flashAddr_t cmdAddr;
    pageIndex_t cmdCount;
    logic bufWrite;
    pageIndex_t bufIndex;
    flashByte_t bufData;
    flashAddr_t rdAddr;
    flashByte_t rdData;
    flashByte_t status;
    logic txActive;
    flashByte_t txByte;
    logic txNext;

    spiShiftIn spiShiftIn_inst (
        .CSNeg_ipd(CSNeg_ipd), .rstN(rstN), .sck(sck), .si(si), .csNeg(csNeg),
        .frameStart(frameStart), .frameEnd(frameEnd), .rxValid(rxValid),
        .rxByte(rxByte), .partialBits(partialBits), .sckFall(sckFall)
    );

    cmdDecoder cmdDecoder_inst (
        .CSNeg_ipd(CSNeg_ipd), .rstN(rstN), .frameStart(frameStart),
        .frameEnd(frameEnd), .rxValid(rxValid), .rxByte(rxByte),
        .partialBits(partialBits), .txNext(txNext), .rdData(rdData),
        .status(status), .cmdValid(cmdValid), .cmd(cmd), .cmdAddr(cmdAddr),
        .cmdCount(cmdCount), .bufWrite(bufWrite), .bufIndex(bufIndex),
        .bufData(bufData), .rdAddr(rdAddr), .txActive(txActive), .txByte(txByte)
    );

    flashCore flashCore_inst (
        .CSNeg_ipd(CSNeg_ipd), .rstN(rstN), .cmdValid(cmdValid), .cmd(cmd),
        .cmdAddr(cmdAddr), .cmdCount(cmdCount), .bufWrite(bufWrite),
        .bufIndex(bufIndex), .bufData(bufData), .rdAddr(rdAddr),
        .rdData(rdData), .status(status)
    );

    spiShiftOut spiShiftOut_inst (
        .CSNeg_ipd(CSNeg_ipd), .rstN(rstN), .sckFall(sckFall),
        .txActive(txActive), .txByte(txByte), .txNext(txNext),
        .so(so), .soEn(soEn)
    );

endmodule

`default_nettype wire

/* spiShiftOut.sv */
////////////////////////////////////////////////////////////////////////////
// SPI transmit side
// Shifts read bytes out MSB first on falling sck
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spiShiftOut import spiFlashPkg::*;
(
    input  wire  CSNeg_ipd,
    input  wire  rstN,
    input  wire  sckFall,
    input  wire  txActive,
    input  wire  [7:0] txByte,
    output logic txNext,
    output logic so,
    output logic soEn
);

    logic [2:0] bitCount;
    logic [6:0] shiftReg;

    always_ff @(posedge CSNeg_ipd or negedge rstN)
    begin
        if (!rstN)
        begin
            bitCount <= 3'd0;
            so <= 1'b0;
            soEn <= 1'b0;
            txNext <= 1'b0;
        end
        else
        begin
            soEn <= txActive;
            txNext <= 1'b0;
            if (!txActive)
            begin
                bitCount <= 3'd0;
                so <= 1'b0;
            end
            else if (sckFall)
            begin
                bitCount <= bitCount + 3'd1;
                // Byte boundary, take the next byte
                if (bitCount == 3'd0)
                begin
                    so <= txByte[7];
                    txNext <= 1'b1;
                end
                else
                    so <= shiftReg[6];
            end
        end
    end

    always_ff @(posedge CSNeg_ipd)
    begin
        if (txActive && sckFall)
            shiftReg <= (bitCount == 3'd0) ? txByte[6:0] : {shiftReg[5:0], 1'b0};
    end

endmodule

`default_nettype wire

/* flashCore.sv */
////////////////////////////////////////////////////////////////////////////
// Flash array core
// Status register, 4 KiB array, page buffer and program/erase engine
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module flashCore import spiFlashPkg::*;
(
    input  wire        CSNeg_ipd,
    input  wire        rstN,
    input  wire        cmdValid,
    input  wire        [7:0] cmd,
    input  wire        [memAddrBits-1:0] cmdAddr,
    input  wire        [8:0] cmdCount,
    input  wire        bufWrite,
    input  wire        [8:0] bufIndex,
    input  wire        [7:0] bufData,
    input  wire        [memAddrBits-1:0] rdAddr,
    output flashByte_t rdData,
    output flashByte_t status
);

    typedef enum logic [2:0] {
        engIdle,
        engProgRead,
        engProgWrite,
        engErase,
        engDone
    } engState_e;

    engState_e engState;
    logic wip;
    logic wel;
    flashAddr_t engAddr;
    pageIndex_t engIdx;
    pageIndex_t engCount;
    flashByte_t oldByte;
    logic sectorLast;

    flashByte_t mem [memBytes];
    flashByte_t pageBuf [pageBytes];

    // Array comes up erased
    initial
    begin
        for (int i = 0; i < memBytes; i++)
            mem[i] = erasedByte;
    end

    assign sectorLast = (engAddr & flashAddr_t'(sectorBytes - 1))
                        == flashAddr_t'(sectorBytes - 1);

    always_comb
    begin
        status = '0;
        status[statusWipBit] = wip;
        status[statusWelBit] = wel;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program / erase engine
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CSNeg_ipd or negedge rstN)
    begin
        if (!rstN)
        begin
            engState <= engIdle;
            wip <= 1'b0;
            wel <= 1'b0;
            engAddr <= '0;
            engIdx <= '0;
            engCount <= '0;
        end
        else
        begin
            case (engState)
                engIdle:
                begin
                    // Commands while busy never reach this branch
                    if (cmdValid)
                    begin
                        case (cmd)
                            opWren: wel <= 1'b1;
                            opWrdi: wel <= 1'b0;
                            opPp:
                            begin
                                if (wel)
                                begin
                                    wip <= 1'b1;
                                    engAddr <= cmdAddr;
                                    engIdx <= '0;
                                    engCount <= cmdCount;
                                    engState <= engProgRead;
                                end
                            end
                            opSe:
                            begin
                                if (wel)
                                begin
                                    wip <= 1'b1;
                                    engAddr <= cmdAddr & ~flashAddr_t'(sectorBytes - 1);
                                    engState <= engErase;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                engProgRead: engState <= engProgWrite;
                engProgWrite:
                begin
                    engAddr <= engAddr + 1'b1;
                    engIdx <= engIdx + 9'd1;
                    engState <= (engIdx == engCount - 9'd1) ? engDone : engProgRead;
                end
                engErase:
                begin
                    engAddr <= engAddr + 1'b1;
                    if (sectorLast)
                        engState <= engDone;
                end
                default:
                begin
                    wip <= 1'b0;
                    wel <= 1'b0;
                    engState <= engIdle;
                end
            endcase
        end
    end

    // Array and page buffer ports
    always_ff @(posedge CSNeg_ipd)
    begin
        rdData <= mem[rdAddr];
        if (bufWrite && !wip)
            pageBuf[bufIndex[7:0]] <= bufData;
        if (engState == engProgRead)
            oldByte <= mem[engAddr];
        // Programming can only clear bits
        if (engState == engProgWrite)
            mem[engAddr] <= oldByte & pageBuf[engIdx[7:0]];
        else if (engState == engErase)
            mem[engAddr] <= erasedByte;
    end

endmodule

`default_nettype wire

/* cmdDecoder.sv */
////////////////////////////////////////////////////////////////////////////
// Bus cycle FSM and command decode
// Collects opcode, address and page data; picks the byte to transmit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cmdDecoder import spiFlashPkg::*;
(
    input  wire        CSNeg_ipd,
    input  wire        rstN,
    input  wire        frameStart,
    input  wire        frameEnd,
    input  wire        rxValid,
    input  wire        [7:0] rxByte,
    input  wire        partialBits,
    input  wire        txNext,
    input  wire        [7:0] rdData,
    input  wire        [7:0] status,
    output logic       cmdValid,
    output spiOpcode_e cmd,
    output flashAddr_t cmdAddr,
    output pageIndex_t cmdCount,
    output logic       bufWrite,
    output pageIndex_t bufIndex,
    output flashByte_t bufData,
    output flashAddr_t rdAddr,
    output logic       txActive,
    output flashByte_t txByte
);

    busState_e busState;
    logic [1:0] addrCount;
    logic dataSeen;
    logic [1:0] idIndex;
    logic frameOk;
    logic ppAccept;
    flashAddr_t addrNext;
    pageIndex_t pageLimit;

    // Only the low address bits survive the shift
    assign addrNext = {cmdAddr[memAddrBits-9:0], rxByte};
    // Bytes left up to the end of the page
    assign pageLimit = pageIndex_t'(pageBytes) - pageIndex_t'(cmdAddr[7:0]);
    assign ppAccept = rxValid && (busState == busData) && (cmd == opPp)
                      && (cmdCount < pageLimit);

    // Byte count check at csNeg rise
    always_comb
    begin
        frameOk = 1'b0;
        if ((busState == busData) && !partialBits)
        begin
            case (cmd)
                opWren, opWrdi, opSe: frameOk = !dataSeen;
                opPp: frameOk = (cmdCount != '0);
                default: frameOk = 1'b0;
            endcase
        end
    end

    always_ff @(posedge CSNeg_ipd or negedge rstN)
    begin
        if (!rstN)
        begin
            busState <= busIdle;
            cmd <= opNone;
            cmdAddr <= '0;
            cmdCount <= '0;
            addrCount <= 2'd0;
            dataSeen <= 1'b0;
            rdAddr <= '0;
            txActive <= 1'b0;
            cmdValid <= 1'b0;
            bufWrite <= 1'b0;
        end
        else
        begin
            cmdValid <= 1'b0;
            bufWrite <= ppAccept;
            // Read address steps once per loaded byte
            if (txActive && txNext && (cmd == opRead))
                rdAddr <= rdAddr + 1'b1;
            if (frameStart)
            begin
                busState <= busCode;
                cmd <= opNone;
                cmdCount <= '0;
                addrCount <= 2'd0;
                dataSeen <= 1'b0;
            end
            else if (frameEnd)
            begin
                busState <= busIdle;
                txActive <= 1'b0;
                cmdValid <= frameOk;
            end
            else if (rxValid)
            begin
                case (busState)
                    busCode:
                    begin
                        cmd <= spiOpcode_e'(rxByte);
                        case (rxByte)
                            opWren, opWrdi: busState <= busData;
                            opRead, opSe, opPp: busState <= busAddr;
                            opRdsr, opRdid:
                            begin
                                busState <= busData;
                                txActive <= 1'b1;
                            end
                            default: busState <= busIgnore;
                        endcase
                    end
                    busAddr:
                    begin
                        cmdAddr <= addrNext;
                        addrCount <= addrCount + 2'd1;
                        if (addrCount == 2'd2)
                        begin
                            busState <= busData;
                            rdAddr <= addrNext;
                            txActive <= (cmd == opRead);
                        end
                    end
                    busData:
                    begin
                        dataSeen <= 1'b1;
                        // Bytes past the page end are dropped
                        if (ppAccept)
                            cmdCount <= cmdCount + 9'd1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Transmit source steps once per loaded byte
    always_ff @(posedge CSNeg_ipd or negedge rstN)
    begin
        if (!rstN)
            idIndex <= 2'd0;
        else if (frameStart)
            idIndex <= 2'd0;
        else if (txActive && txNext && (cmd == opRdid))
            idIndex <= (idIndex == 2'd2) ? 2'd0 : idIndex + 2'd1;
    end

    always_ff @(posedge CSNeg_ipd)
    begin
        if (ppAccept)
        begin
            bufIndex <= cmdCount;
            bufData <= rxByte;
        end
    end

    always_comb
    begin
        case (cmd)
            opRdsr: txByte = status;
            opRdid:
            begin
                case (idIndex)
                    2'd0: txByte = deviceId[23:16];
                    2'd1: txByte = deviceId[15:8];
                    default: txByte = deviceId[7:0];
                endcase
            end
            default: txByte = rdData;
        endcase
    end

endmodule

`default_nettype wire

/* spiShiftIn.sv */
////////////////////////////////////////////////////////////////////////////
// SPI receive side
// Synchronizes the pins, finds sck and csNeg edges, assembles bytes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spiShiftIn import spiFlashPkg::*;
(
    input  wire        CSNeg_ipd,
    input  wire        rstN,
    input  wire        sck,
    input  wire        si,
    input  wire        csNeg,
    output logic       frameStart,
    output logic       frameEnd,
    output logic       rxValid,
    output flashByte_t rxByte,
    output logic       partialBits,
    output logic       sckFall
);

    logic [1:0] sckSync;
    logic [1:0] csSync;
    logic [1:0] siSync;
    logic sckPrev;
    logic csPrev;
    logic sckRise;
    logic [2:0] bitCount;
    logic [6:0] shiftReg;

    // Two flop synchronizers plus one stage for edge detect
    always_ff @(posedge CSNeg_ipd or negedge rstN)
    begin
        if (!rstN)
        begin
            sckSync <= 2'b00;
            csSync <= 2'b11;
            siSync <= 2'b00;
            sckPrev <= 1'b0;
            csPrev <= 1'b1;
        end
        else
        begin
            sckSync <= {sckSync[0], sck};
            csSync <= {csSync[0], csNeg};
            siSync <= {siSync[0], si};
            sckPrev <= sckSync[1];
            csPrev <= csSync[1];
        end
    end

    assign frameStart = csPrev & ~csSync[1];
    assign frameEnd = ~csPrev & csSync[1];
    // sck edges only count while selected
    assign sckRise = sckSync[1] & ~sckPrev & ~csSync[1];
    assign sckFall = ~sckSync[1] & sckPrev & ~csSync[1];

    always_ff @(posedge CSNeg_ipd or negedge rstN)
    begin
        if (!rstN)
            bitCount <= 3'd0;
        else if (frameStart)
            bitCount <= 3'd0;
        else if (sckRise)
            bitCount <= bitCount + 3'd1;
    end

    always_ff @(posedge CSNeg_ipd)
    begin
        if (frameStart)
            shiftReg <= '0;
        else if (sckRise)
            shiftReg <= {shiftReg[5:0], siSync[1]};
    end

    // Eighth bit completes the byte, MSB first
    assign rxValid = sckRise && (bitCount == 3'd7);
    assign rxByte = {shiftReg, siSync[1]};
    assign partialBits = (bitCount != 3'd0);

endmodule

`default_nettype wire

/* spiFlashPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Serial flash shared definitions
// Array sizes, opcodes, bus cycle states and data types
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package spiFlashPkg;

    // Scaled down array, 4 KiB in four sectors
    localparam int memAddrBits = 12;
    localparam int memBytes = 4096;
    localparam int pageBytes = 256;
    localparam int sectorBytes = 1024;

    // Manufacturer, memory type, capacity
    localparam logic [23:0] deviceId = 24'h010207;
    localparam logic [7:0] erasedByte = 8'hFF;

    // Status register bit positions
    localparam int statusWipBit = 0;
    localparam int statusWelBit = 1;

    typedef logic [7:0] flashByte_t;
    typedef logic [memAddrBits-1:0] flashAddr_t;
    typedef logic [8:0] pageIndex_t;

    typedef enum logic [7:0] {
        opNone = 8'h00,
        opWrdi = 8'h04,
        opWren = 8'h06,
        opRdsr = 8'h05,
        opRead = 8'h03,
        opPp   = 8'h02,
        opSe   = 8'hD8,
        opRdid = 8'h9F
    } spiOpcode_e;

    typedef enum logic [2:0] {
        busIdle,
        busCode,
        busAddr,
        busData,
        busIgnore
    } busState_e;

endpackage

`default_nettype wire
